//--- msx_io_tests.txt
# kind name addr data ctl expect, all hex; iord ctl bits m1 msx2 rd_n, expect sel then ppi byte
# audio uses addr as cart sound, data as cas audio, ctl as psg sound; m1 ctl 1 holds m1_n low
mem   slot_rst_p0  0000 00 0   0
mem   slot_rst_p3  c000 00 0   0
iord  vdp_rd       0098 00 2   800
iord  psg_rd       00a2 00 2   400
iord  rtc_msx2     00b4 00 2   100
iord  rtc_msx1     00b4 00 0   000
iord  rd_idle      009f 00 3   800
iord  m1_ack       0098 00 6   000
iord  kb_col       00a9 5a 2   25a
iowr  psl_wr       00a8 e4 0   00
iord  psl_rd       00a8 00 2   2e4
mem   slot_p0      0123 00 0   0
mem   slot_p1      4000 00 0   1
mem   slot_p2      8abc 00 0   2
mem   slot_p3      ffff 00 0   3
iowr  pc_wr        00aa 1a 0   1a
iord  pc_rd        00aa 00 2   21a
iowr  bsr_mclr     00ab 08 0   0a
iowr  bsr_kon      00ab 0f 0   0a
iord  bsr_rd1      00aa 00 2   28a
iowr  bsr_mset     00ab 09 0   1a
iowr  mode_word    00ab 82 0   1a
iord  bsr_rd2      00aa 00 2   29a
audio aud_click    0000 01 010 0600
iowr  bsr_koff     00ab 0e 0   1a
audio aud_noclick  0000 01 010 0200
iowr  bsr_moff     00ab 08 0   0a
audio aud_cas      0000 01 010 0400
audio aud_pass     1234 00 005 2508
audio aud_neg      f000 00 000 e000
audio aud_sat_pos  3000 00 100 7fff
audio aud_sat_neg  8000 00 000 8000
m1    m1_fetch1    0000 00 1   6
m1    m1_fetch2    0100 00 1   6
m1    m1_none      0000 00 0   0

//--- flist.f
msx_bus_pkg.sv
msx_cfg_pkg.sv
msx_io_decode.sv
msx_ppi.sv
msx_wait_gen.sv
msx_audio_mix.sv
msx_io.sv
tb_msx_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the msx i/o testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_msx_io -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_msx_io
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
fi
exit $status

//--- tb_msx_io.sv
`default_nettype none

module tb_msx_io;

   logic                                    clk21m;
   logic                                    exwait_n;
   msx_bus_pkg::z80_bus_t                   bus_i;
   logic                                    ce_3m58_i = 1'b0;
   msx_cfg_pkg::msx_cfg_t                   cfg_i;
   logic        [7:0]                       kb_col_i;
   logic        [msx_cfg_pkg::PSG_W-1:0]    psg_sound_i;
   logic signed [msx_cfg_pkg::CART_W-1:0]   cart_sound_i;
   logic                                    cas_audio_i;
   logic        [7:0]                       vdp_rd_i;
   logic        [7:0]                       rtc_rd_i;
   logic        [7:0]                       psg_rd_i;
   logic        [7:0]                       slot_rd_i;
   logic        [7:0]                       cpu_di_o;
   logic                                    wait_n_o;
   msx_bus_pkg::io_sel_t                    sel_o;
   logic        [1:0]                       slot_o;
   logic        [3:0]                       kb_row_o;
   logic                                    cas_motor_o;
   logic signed [msx_cfg_pkg::AUDIO_W-1:0]  audio_o;
   int                                      ce_cnt = 0;

   msx_io u_dut (.*);

   initial begin
      clk21m = 1'b0;
      forever #20 clk21m = ~clk21m;
   end

   // 3.58 MHz enable, one clock in six
   always @(negedge clk21m) begin
      ce_cnt    <= (ce_cnt == 5) ? 0 : ce_cnt + 1;
      ce_3m58_i <= (ce_cnt == 5);
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_byte(input logic [127:0] name, input logic [7:0] exp,
                             input logic [7:0] act);
      if (act !== exp) abort_run($sformatf("FAIL %0s expected %02h actual %02h", name, exp, act));
   endtask

   task automatic check_sel(input logic [127:0] name, input msx_bus_pkg::io_sel_t exp,
                            input msx_bus_pkg::io_sel_t act);
      if (act !== exp) abort_run($sformatf("FAIL %0s expected %04b actual %04b", name, exp, act));
   endtask

   task automatic check_slot(input logic [127:0] name, input logic [1:0] exp,
                             input logic [1:0] act);
      if (act !== exp) abort_run($sformatf("FAIL %0s expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_audio(input logic [127:0] name,
                              input logic signed [msx_cfg_pkg::AUDIO_W-1:0] exp,
                              input logic signed [msx_cfg_pkg::AUDIO_W-1:0] act);
      if (act !== exp) abort_run($sformatf("FAIL %0s expected %04h actual %04h", name, exp, act));
   endtask

   task automatic check_wait(input logic [127:0] name, input int exp, input int act);
      if (act != exp) abort_run($sformatf("FAIL %0s expected %0d actual %0d", name, exp, act));
   endtask

   task automatic bus_idle();
      bus_i.iorq_n = 1'b1;
      bus_i.mreq_n = 1'b1;
      bus_i.rd_n   = 1'b1;
      bus_i.wr_n   = 1'b1;
      bus_i.m1_n   = 1'b1;
   endtask

   // n returns the clocks spent before wait_n_o reached level
   task automatic wait_for_wait_n(input logic level, input int limit, output int n);
      n = 0;
      while (wait_n_o !== level) begin
         if (n == limit) abort_run($sformatf("timeout, wait_n_o never went to %0b", level));
         @(negedge clk21m);
         n++;
      end
   endtask

   // returns once the DUT has clocked in one ce pulse
   task automatic wait_for_ce(input int limit);
      int n;
      n = 0;
      do begin
         @(negedge clk21m);
         n++;
         if (n > limit) abort_run("timeout, no ce_3m58_i pulse was seen");
      end while (ce_3m58_i !== 1'b1);
   endtask

   initial begin
      int                   fd;
      int                   n;
      int                   cnt;
      int                   tests;
      int                   page;
      logic [639:0]         line;
      logic [127:0]         kind;
      logic [127:0]         name;
      logic [31:0]          addr;
      logic [31:0]          data;
      logic [31:0]          ctl;
      logic [31:0]          expv;
      msx_bus_pkg::io_sel_t exp_sel;
      logic [7:0]           exp_di;

      void'($urandom(50));
      exwait_n = 1'b0;
      bus_i = '0;
      bus_idle();
      cfg_i.msx_typ = msx_cfg_pkg::MSX2;
      kb_col_i = '0;
      psg_sound_i = '0;
      cart_sound_i = '0;
      cas_audio_i = 1'b0;
      vdp_rd_i = '0;
      rtc_rd_i = '0;
      psg_rd_i = '0;
      slot_rd_i = '0;
      tests = 0;
      // one reset cycle per page, slot map still unset
      for (page = 0; page < 4; page++) begin
         bus_i.addr = {page[1:0], 14'h0000};
         @(negedge clk21m);
         check_slot("rst_slot", 2'b00, slot_o);
      end
      check_byte("rst_wait", 8'h01, {7'b0, wait_n_o});
      check_byte("rst_ppi", 8'h00, {3'b0, cas_motor_o, kb_row_o});
      check_audio("rst_audio", 16'sh0000, audio_o);
      exwait_n = 1'b1;

      fd = $fopen("msx_io_tests.txt", "r");
      if (fd == 0) abort_run("could not open msx_io_tests.txt");
      while (!$feof(fd)) begin
         line = '0;
         kind = '0;
         name = '0;
         n = $fgets(line, fd);
         n = $sscanf(line, "%s %s %h %h %h %h", kind, name, addr, data, ctl, expv);
         if (n == 6 && kind != "#") begin
            tests++;
            @(negedge clk21m);
            bus_i.addr = addr[15:0];
            bus_i.dout = data[7:0];
            vdp_rd_i = 8'($urandom);
            rtc_rd_i = 8'($urandom);
            psg_rd_i = 8'($urandom);
            slot_rd_i = 8'($urandom);
            case (kind)
               "iowr": begin
                  bus_i.iorq_n = 1'b0;
                  bus_i.wr_n   = 1'b0;
                  @(negedge clk21m);
                  bus_idle();
                  check_byte(name, expv[7:0], {3'b0, cas_motor_o, kb_row_o});
               end
               "iord": begin
                  cfg_i.msx_typ = ctl[1] ? msx_cfg_pkg::MSX2 : msx_cfg_pkg::MSX1;
                  kb_col_i = data[7:0];
                  bus_i.iorq_n = 1'b0;
                  bus_i.rd_n   = ctl[0];
                  bus_i.m1_n   = ~ctl[2];
                  @(negedge clk21m);
                  exp_sel = expv[11:8];
                  // read data priority vdp, rtc, psg, ppi, slots
                  if (ctl[0]) exp_di = 8'hFF;
                  else if (exp_sel.vdp) exp_di = vdp_rd_i;
                  else if (exp_sel.rtc) exp_di = rtc_rd_i;
                  else if (exp_sel.psg) exp_di = psg_rd_i;
                  else if (exp_sel.ppi) exp_di = expv[7:0];
                  else exp_di = slot_rd_i;
                  check_sel(name, exp_sel, sel_o);
                  check_byte(name, exp_di, cpu_di_o);
                  bus_idle();
               end
               "mem": begin
                  bus_i.mreq_n = 1'b0;
                  bus_i.rd_n   = 1'b0;
                  @(negedge clk21m);
                  check_slot(name, expv[1:0], slot_o);
                  check_byte(name, slot_rd_i, cpu_di_o);
                  bus_idle();
               end
               "audio": begin
                  cart_sound_i = addr[15:0];
                  cas_audio_i = data[0];
                  psg_sound_i = ctl[9:0];
                  @(negedge clk21m);
                  check_audio(name, expv[15:0], audio_o);
               end
               "m1": begin
                  cnt = 0;
                  if (ctl[0]) begin
                     bus_i.m1_n   = 1'b0;
                     bus_i.mreq_n = 1'b0;
                     bus_i.rd_n   = 1'b0;
                     wait_for_wait_n(1'b0, 12, cnt);
                     wait_for_wait_n(1'b1, 12, cnt);
                     // fetch held over two more ce pulses, no second wait
                     repeat (12) begin
                        @(negedge clk21m);
                        if (wait_n_o === 1'b0) cnt++;
                     end
                     bus_idle();
                     // fsm re-arms only at a ce pulse with m1 high
                     wait_for_ce(12);
                  end else begin
                     repeat (12) begin
                        @(negedge clk21m);
                        if (wait_n_o === 1'b0) cnt++;
                     end
                  end
                  check_wait(name, int'(expv), cnt);
               end
               default: abort_run($sformatf("unknown test kind %0s in %0s", kind, name));
            endcase
         end
      end
      $fclose(fd);
      if (tests == 0) begin
         abort_run("no test vectors were read");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- msx_io.sv
`default_nettype none

module msx_io (
   input  logic                                    clk21m,
   input  logic                                    exwait_n,
   input  msx_bus_pkg::z80_bus_t                   bus_i,
   input  logic                                    ce_3m58_i,
   input  msx_cfg_pkg::msx_cfg_t                   cfg_i,
   input  logic        [7:0]                       kb_col_i,
   input  logic        [msx_cfg_pkg::PSG_W-1:0]    psg_sound_i,
   input  logic signed [msx_cfg_pkg::CART_W-1:0]   cart_sound_i,
   input  logic                                    cas_audio_i,
   input  logic        [7:0]                       vdp_rd_i,
   input  logic        [7:0]                       rtc_rd_i,
   input  logic        [7:0]                       psg_rd_i,
   input  logic        [7:0]                       slot_rd_i,
   output logic        [7:0]                       cpu_di_o,
   output logic                                    wait_n_o,
   output msx_bus_pkg::io_sel_t                    sel_o,
   output logic        [1:0]                       slot_o,
   output logic        [3:0]                       kb_row_o,
   output logic                                    cas_motor_o,
   output logic signed [msx_cfg_pkg::AUDIO_W-1:0]  audio_o
);

   logic [7:0] ppi_rd;
   logic       key_click;

   msx_io_decode u_decode (
      .bus_i     (bus_i),
      .cfg_i     (cfg_i),
      .vdp_rd_i  (vdp_rd_i),
      .rtc_rd_i  (rtc_rd_i),
      .psg_rd_i  (psg_rd_i),
      .ppi_rd_i  (ppi_rd),
      .slot_rd_i (slot_rd_i),
      .sel_o     (sel_o),
      .cpu_di_o  (cpu_di_o)
   );

   msx_ppi u_ppi (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .bus_i       (bus_i),
      .ppi_sel_i   (sel_o.ppi),
      .kb_col_i    (kb_col_i),
      .ppi_rd_o    (ppi_rd),
      .slot_o      (slot_o),
      .kb_row_o    (kb_row_o),
      .cas_motor_o (cas_motor_o),
      .key_click_o (key_click)
   );

   msx_wait_gen u_wait (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .m1_n_i    (bus_i.m1_n),
      .ce_3m58_i (ce_3m58_i),
      .wait_n_o  (wait_n_o)
   );

   msx_audio_mix u_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .psg_sound_i  (psg_sound_i),
      .key_click_i  (key_click),
      .cas_audio_i  (cas_audio_i),
      .cas_motor_i  (cas_motor_o),
      .cart_sound_i (cart_sound_i),
      .audio_o      (audio_o)
   );

endmodule

`default_nettype wire

//--- msx_audio_mix.sv
`default_nettype none

module msx_audio_mix (
   input  logic                                    clk21m,
   input  logic                                    exwait_n,
   input  logic        [msx_cfg_pkg::PSG_W-1:0]    psg_sound_i,
   input  logic                                    key_click_i,
   input  logic                                    cas_audio_i,
   input  logic                                    cas_motor_i,
   input  logic signed [msx_cfg_pkg::CART_W-1:0]   cart_sound_i,
   output logic signed [msx_cfg_pkg::AUDIO_W-1:0]  audio_o
);

   localparam int CW = msx_cfg_pkg::CART_W;
   localparam int AW = msx_cfg_pkg::AUDIO_W;

   logic [msx_cfg_pkg::PSG_W-1:0] psg_mix;
   logic [CW:0]                   fm;
   logic [CW:0]                   sum;
   logic [AW-1:0]                 sat;

   // click and tape monitor ride on the psg level, wraps in 10 bits
   assign psg_mix = psg_sound_i + {key_click_i, 5'b00000} +
                    {cas_audio_i & ~cas_motor_i, 4'b0000};
   assign fm      = {{(CW - msx_cfg_pkg::PSG_W - 3){1'b0}}, psg_mix, 4'b0000};
   assign sum     = {cart_sound_i[CW-1], cart_sound_i} + fm;

   // top three bits agree, so the sum fits after dropping two of them
   always_comb begin
      case (sum[CW:CW-2])
         3'b000, 3'b111: sat = {sum[CW], sum[CW-3:0], 1'b0};
         default:        sat = sum[CW] ? {1'b1, {(AW-1){1'b0}}} : {1'b0, {(AW-1){1'b1}}};
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         audio_o <= '0;
      end else begin
         audio_o <= sat;
      end
   end

endmodule

`default_nettype wire

//--- msx_wait_gen.sv
`default_nettype none

module msx_wait_gen (
   input  logic clk21m,
   input  logic exwait_n,
   input  logic m1_n_i,
   input  logic ce_3m58_i,
   output logic wait_n_o
);

   logic wait_q;
   logic done_q;

   // one wait period per opcode fetch
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_q <= 1'b0;
         done_q <= 1'b0;
      end else if (ce_3m58_i) begin
         if (m1_n_i) begin
            // m1 over, arm for the next fetch
            wait_q <= 1'b0;
            done_q <= 1'b0;
         end else if (wait_q) begin
            wait_q <= 1'b0;
            done_q <= 1'b1;
         end else if (!done_q) begin
            wait_q <= 1'b1;
         end
      end
   end

   assign wait_n_o = ~wait_q;

endmodule

`default_nettype wire

//--- msx_ppi.sv
`default_nettype none

module msx_ppi (
   input  logic                  clk21m,
   input  logic                  exwait_n,
   input  msx_bus_pkg::z80_bus_t bus_i,
   input  logic                  ppi_sel_i,
   input  logic [7:0]            kb_col_i,
   output logic [7:0]            ppi_rd_o,
   output logic [1:0]            slot_o,
   output logic [3:0]            kb_row_o,
   output logic                  cas_motor_o,
   output logic                  key_click_o
);

   msx_bus_pkg::psl_reg_u port_a;
   logic [7:0]            port_c;
   logic                  map_valid;
   logic                  ppi_wr;
   logic [1:0]            page_slot;

   assign ppi_wr = ppi_sel_i & ~bus_i.wr_n;

   // register writes, offset in addr[1:0]
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a.raw <= '0;
         port_c     <= '0;
      end else if (ppi_wr) begin
         case (bus_i.addr[1:0])
            2'd0: port_a.raw <= bus_i.dout;
            2'd2: port_c     <= bus_i.dout;
            2'd3: begin
               // bit set/reset, mode words are dropped
               if (!bus_i.dout[7]) begin
                  port_c[bus_i.dout[3:1]] <= bus_i.dout[0];
               end
            end
            // port b is input only
            default: ;
         endcase
      end
   end

   // slot map holds garbage until the bios touches the ppi
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         map_valid <= 1'b0;
      end else if (ppi_sel_i) begin
         map_valid <= 1'b1;
      end
   end

   always_comb begin
      case (bus_i.addr[1:0])
         2'd0:    ppi_rd_o = port_a.raw;
         2'd1:    ppi_rd_o = kb_col_i;
         2'd2:    ppi_rd_o = port_c;
         default: ppi_rd_o = msx_bus_pkg::PPI_MODE_WORD;
      endcase
   end

   // page field for the current cpu address
   always_comb begin
      case (bus_i.addr[15:14])
         2'd0:    page_slot = port_a.pages.page0;
         2'd1:    page_slot = port_a.pages.page1;
         2'd2:    page_slot = port_a.pages.page2;
         default: page_slot = port_a.pages.page3;
      endcase
   end

   assign slot_o = map_valid ? page_slot : 2'b00;

   assign kb_row_o    = port_c[3:0];
   assign cas_motor_o = port_c[4];
   assign key_click_o = port_c[7];

endmodule

`default_nettype wire

//--- msx_io_decode.sv
`default_nettype none

module msx_io_decode (
   input  msx_bus_pkg::z80_bus_t bus_i,
   input  msx_cfg_pkg::msx_cfg_t cfg_i,
   input  logic [7:0]            vdp_rd_i,
   input  logic [7:0]            rtc_rd_i,
   input  logic [7:0]            psg_rd_i,
   input  logic [7:0]            ppi_rd_i,
   input  logic [7:0]            slot_rd_i,
   output msx_bus_pkg::io_sel_t  sel_o,
   output logic [7:0]            cpu_di_o
);

   logic io_cyc;
   logic is_msx2;

   // interrupt acknowledge also drives iorq_n, so m1 must be high
   assign io_cyc  = ~bus_i.iorq_n & bus_i.m1_n;
   assign is_msx2 = (cfg_i.msx_typ == msx_cfg_pkg::MSX2);

   always_comb begin
      sel_o     = '0;
      sel_o.vdp = io_cyc && (bus_i.addr[7:3] == msx_bus_pkg::PORT_VDP);
      sel_o.psg = io_cyc && (bus_i.addr[7:3] == msx_bus_pkg::PORT_PSG);
      sel_o.ppi = io_cyc && (bus_i.addr[7:2] == msx_bus_pkg::PORT_PPI);
      // msx1 has no clock chip
      sel_o.rtc = io_cyc && is_msx2 &&
                  (bus_i.addr[7:1] == msx_bus_pkg::PORT_RTC);
   end

   // cpu read data, fixed priority
   always_comb begin
      if (bus_i.rd_n) begin
         cpu_di_o = 8'hFF;
      end else if (sel_o.vdp) begin
         cpu_di_o = vdp_rd_i;
      end else if (sel_o.rtc) begin
         cpu_di_o = rtc_rd_i;
      end else if (sel_o.psg) begin
         cpu_di_o = psg_rd_i;
      end else if (sel_o.ppi) begin
         cpu_di_o = ppi_rd_i;
      end else begin
         // memory and unclaimed ports fall through to the slots
         cpu_di_o = slot_rd_i;
      end
   end

endmodule

`default_nettype wire

//--- msx_cfg_pkg.sv
`default_nettype none

package msx_cfg_pkg;

   typedef enum logic {
      MSX1 = 1'b0,
      MSX2 = 1'b1
   } machine_t;

   // machine configuration, static while running
   typedef struct packed {
      machine_t msx_typ;
   } msx_cfg_t;

   // psg channel mix, unsigned
   localparam int PSG_W   = 10;
   // cartridge sound, signed
   localparam int CART_W  = 16;
   // mixer output, signed
   localparam int AUDIO_W = 16;

endpackage

`default_nettype wire

//--- msx_bus_pkg.sv
`default_nettype none

package msx_bus_pkg;

   // cpu outputs as every peripheral sees them
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        iorq_n;
      logic        mreq_n;
      logic        rd_n;
      logic        wr_n;
      logic        m1_n;
   } z80_bus_t;

   // active high, i/o cycles outside m1 only
   typedef struct packed {
      logic vdp;
      logic psg;
      logic ppi;
      logic rtc;
   } io_sel_t;

   // one slot number per 16 kb page, page0 in the low bits
   typedef struct packed {
      logic [1:0] page3;
      logic [1:0] page2;
      logic [1:0] page1;
      logic [1:0] page0;
   } psl_pages_t;

   // port a as the cpu sees it and as the slot selector sees it
   typedef union packed {
      logic [7:0] raw;
      psl_pages_t pages;
   } psl_reg_u;

   // upper bits of the low port address byte
   localparam logic [4:0] PORT_VDP = 5'b10011;   // 98h-9fh
   localparam logic [4:0] PORT_PSG = 5'b10100;   // a0h-a7h
   localparam logic [5:0] PORT_PPI = 6'b101010;  // a8h-abh
   localparam logic [6:0] PORT_RTC = 7'b1011010; // b4h-b5h

   // mode 0 control word: port a out, port b in, port c out
   localparam logic [7:0] PPI_MODE_WORD = 8'h82;

endpackage

`default_nettype wire
